//--- rtl/adc_pkg.sv
package adc_pkg;

    // ****************************************
    // Sizes and frame timing
    // ****************************************
    localparam int SAMPLE_W    = 12;
    localparam int SCLK_DIV    = 2;                         // clk cycles per sclk half period
    localparam int FRAME_SCLKS = 16;                        // Four leading zeros, then 12 bits
    localparam int CAL_SCLKS   = 32;
    localparam int QUIET_SCLKS = 2;
    localparam int MIN_PERIOD  = (FRAME_SCLKS + QUIET_SCLKS) * 2 * SCLK_DIV;
    localparam int QUIET_CLKS  = QUIET_SCLKS * 2 * SCLK_DIV;
    localparam int FIFO_DEPTH  = 16;

    localparam int DIV_W    = $clog2(SCLK_DIV + 1);
    localparam int BIT_W    = $clog2(CAL_SCLKS + 1);
    localparam int QUIET_W  = $clog2(QUIET_CLKS + 1);
    localparam int PERIOD_W = 16;
    localparam int PTR_W    = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W  = $clog2(FIFO_DEPTH + 1);

    // ****************************************
    // Register map
    // ****************************************
    localparam int AXI_W = 32;
    localparam int REG_W = 8;                               // Offset bits that get decoded

    localparam logic [REG_W-1:0] REG_CTRL   = 8'h00;
    localparam logic [REG_W-1:0] REG_STATUS = 8'h04;
    localparam logic [REG_W-1:0] REG_DATA   = 8'h08;
    localparam logic [REG_W-1:0] REG_PERIOD = 8'h0C;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_RECAL_BIT  = 1;
    localparam int STAT_AVAIL_BIT  = 0;
    localparam int STAT_CAL_BIT    = 1;
    localparam int STAT_LEVEL_LSB  = 4;
    localparam int DATA_OVR_BIT    = 16;
    localparam int DATA_VALID_BIT  = 31;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Reader FSM states
    typedef enum logic [1:0] {
        INIT      = 2'b00,
        CALIBRATE = 2'b01,
        IDLE      = 2'b10,
        RECEIVE   = 2'b11
    } reader_state_t;

    typedef struct packed {
        logic                overrun;                       // Samples were lost before this one
        logic [SAMPLE_W-1:0] value;
    } sample_t;

    typedef struct packed {
        logic                enable;
        logic [PERIOD_W-1:0] period;                        // In clk cycles
    } adc_cfg_t;

    typedef struct packed { logic [AXI_W-1:0] addr; } axil_aw_t;
    typedef struct packed { logic [AXI_W-1:0] data; } axil_w_t;
    typedef struct packed { logic [1:0] resp; } axil_b_t;
    typedef struct packed { logic [AXI_W-1:0] addr; } axil_ar_t;

    typedef struct packed {
        logic [AXI_W-1:0] data;
        logic [1:0]       resp;
    } axil_r_t;

endpackage

//--- rtl/adc_spi_reader.sv
module adc_spi_reader import adc_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  adc_cfg_t cfg,
    input  logic     recal_req,
    input  logic     sdo,
    input  logic     in_ready,
    output logic     cs,
    output logic     sclk,
    output sample_t  smp,
    output logic     smp_valid,
    output logic     calibrating
);

    reader_state_t       state;
    logic [DIV_W-1:0]    div_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [SAMPLE_W-1:0] shift;
    logic [PERIOD_W-1:0] period_cnt;
    logic [PERIOD_W-1:0] reload;
    logic [QUIET_W-1:0]  quiet_cnt;
    logic                recal_pend;
    logic                ovr_pend;

    logic in_frame;
    logic sclk_en;
    logic rise;
    logic fall;
    logic last_bit;
    logic start_cal;
    logic start_conv;
    logic capture;
    logic capture_last;

    // ****************************************
    // Serial clock enable and frame control
    // ****************************************
    assign in_frame = (state == CALIBRATE) || (state == RECEIVE);
    assign sclk_en  = in_frame && (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign rise     = sclk_en && !sclk;
    assign fall     = sclk_en && sclk;

    assign last_bit = (state == RECEIVE) ? (bit_cnt == BIT_W'(FRAME_SCLKS))
                                         : (bit_cnt == BIT_W'(CAL_SCLKS));

    // Recalibration wins over a due conversion
    assign start_cal  = (state == INIT) ||
                        ((state == IDLE) && (quiet_cnt == '0) && recal_pend);
    assign start_conv = (state == IDLE) && (quiet_cnt == '0) && !recal_pend &&
                        cfg.enable && (period_cnt == '0);

    assign reload = (cfg.period < PERIOD_W'(MIN_PERIOD)) ? PERIOD_W'(MIN_PERIOD - 1)
                                                         : cfg.period - PERIOD_W'(1);

    assign calibrating = (state == INIT) || (state == CALIBRATE) || recal_pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= INIT;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            quiet_cnt <= '0;
        end else begin
            case (state)
                INIT, IDLE: begin
                    if (quiet_cnt != '0)
                        quiet_cnt <= quiet_cnt - 1'b1;
                    if (start_cal || start_conv) begin
                        state   <= start_cal ? CALIBRATE : RECEIVE;
                        cs      <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                CALIBRATE, RECEIVE: begin
                    div_cnt <= sclk_en ? '0 : div_cnt + 1'b1;
                    if (sclk_en)
                        sclk <= !sclk;
                    if (rise)
                        bit_cnt <= bit_cnt + 1'b1;
                    if (fall && last_bit) begin                     // Frame ends on last falling edge
                        state     <= IDLE;
                        cs        <= 1'b1;
                        quiet_cnt <= QUIET_W'(QUIET_CLKS - 1);
                    end
                end
            endcase
        end
    end

    // Conversion period, counted from one frame start to the next
    always_ff @(posedge clk) begin
        if (reset)
            period_cnt <= '0;
        else if (start_conv)
            period_cnt <= reload;
        else if (period_cnt != '0)
            period_cnt <= period_cnt - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            recal_pend <= 1'b0;
        else
            recal_pend <= recal_req || (recal_pend && !start_cal);
    end

    // ****************************************
    // Data capture and sample output
    // ****************************************
    assign capture      = rise && (state == RECEIVE);
    assign capture_last = capture && (bit_cnt == BIT_W'(FRAME_SCLKS - 1));

    always_ff @(posedge clk) begin
        if (capture)
            shift <= {shift[SAMPLE_W-2:0], sdo};                    // Leading zeros fall off the top
        if (capture_last) begin
            smp.value   <= {shift[SAMPLE_W-2:0], sdo};
            smp.overrun <= ovr_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            smp_valid <= 1'b0;
            ovr_pend  <= 1'b0;
        end else begin
            smp_valid <= capture_last;
            if (smp_valid)
                ovr_pend <= !in_ready;                              // The ADC cannot wait for space
        end
    end

endmodule

//--- rtl/sample_fifo.sv
module sample_fifo import adc_pkg::*; #(
    parameter type payload_t = logic [7:0]
) (
    input  logic               clk,
    input  logic               reset,
    input  payload_t           in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output payload_t           out_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [LEVEL_W-1:0] level
);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign in_ready  = (level != LEVEL_W'(FIFO_DEPTH));
    assign out_valid = (level != '0);
    assign push      = in_valid && in_ready;                        // Ignored when full
    assign pop       = out_ready && out_valid;
    assign out_data  = mem[rd_ptr];                                 // Head is visible without delay

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;                            // Depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

//--- rtl/adc_axil_regs.sv
module adc_axil_regs import adc_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  axil_aw_t           aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  axil_w_t            w,
    input  logic               w_valid,
    output logic               w_ready,
    output axil_b_t            b,
    output logic               b_valid,
    input  logic               b_ready,
    input  axil_ar_t           ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output axil_r_t            r,
    output logic               r_valid,
    input  logic               r_ready,

    input  sample_t            fifo_data,
    input  logic               fifo_valid,
    input  logic [LEVEL_W-1:0] fifo_level,
    input  logic               calibrating,
    output adc_cfg_t           cfg,
    output logic               recal_req,
    output logic               pop
);

    axil_aw_t         aw_q;
    axil_w_t          w_q;
    logic             aw_held;
    logic             w_held;
    logic             aw_fire;
    logic             w_fire;
    logic             do_write;
    logic             aw_held_n;
    logic             w_held_n;
    logic             b_valid_n;
    logic [AXI_W-1:0] wr_addr;
    logic [AXI_W-1:0] wr_data;
    logic             wr_ctrl;
    logic             wr_period;
    logic             ar_fire;
    logic             r_valid_n;
    axil_r_t          rd;

    // ****************************************
    // Write channels
    // ****************************************
    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    assign do_write  = (aw_held || aw_fire) && (w_held || w_fire);  // AW and W in either order
    assign aw_held_n = (aw_held || aw_fire) && !do_write;
    assign w_held_n  = (w_held || w_fire) && !do_write;
    assign b_valid_n = do_write || (b_valid && !b_ready);

    assign wr_addr   = aw_fire ? aw.addr : aw_q.addr;
    assign wr_data   = w_fire ? w.data : w_q.data;
    assign wr_ctrl   = (wr_addr[REG_W-1:0] == REG_CTRL);
    assign wr_period = (wr_addr[REG_W-1:0] == REG_PERIOD);

    always_ff @(posedge clk) begin
        if (aw_fire)
            aw_q <= aw;
        if (w_fire)
            w_q <= w;
        if (do_write)
            b.resp <= (wr_ctrl || wr_period) ? RESP_OKAY : RESP_SLVERR;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            aw_held  <= aw_held_n;
            w_held   <= w_held_n;
            b_valid  <= b_valid_n;
            aw_ready <= !aw_held_n && !b_valid_n;                   // One response in flight at most
            w_ready  <= !w_held_n && !b_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.enable <= 1'b0;
            cfg.period <= PERIOD_W'(MIN_PERIOD);
            recal_req  <= 1'b0;
        end else begin
            recal_req <= do_write && wr_ctrl && wr_data[CTRL_RECAL_BIT];
            if (do_write && wr_ctrl)
                cfg.enable <= wr_data[CTRL_ENABLE_BIT];
            if (do_write && wr_period)
                cfg.period <= wr_data[PERIOD_W-1:0];
        end
    end

    // ****************************************
    // Read channels
    // ****************************************
    assign ar_fire   = ar_valid && ar_ready;
    assign r_valid_n = ar_fire || (r_valid && !r_ready);
    assign pop       = ar_fire && (ar.addr[REG_W-1:0] == REG_DATA) && fifo_valid;

    always_comb begin
        rd.data = '0;
        rd.resp = RESP_OKAY;
        case (ar.addr[REG_W-1:0])
            REG_CTRL: rd.data[CTRL_ENABLE_BIT] = cfg.enable;
            REG_STATUS: begin
                rd.data[STAT_AVAIL_BIT]              = fifo_valid;
                rd.data[STAT_CAL_BIT]                = calibrating;
                rd.data[STAT_LEVEL_LSB +: LEVEL_W]   = fifo_level;
            end
            REG_DATA: begin
                if (fifo_valid) begin                               // Empty FIFO reads as zero
                    rd.data[DATA_VALID_BIT] = 1'b1;
                    rd.data[DATA_OVR_BIT]   = fifo_data.overrun;
                    rd.data[SAMPLE_W-1:0]   = fifo_data.value;
                end
            end
            REG_PERIOD: rd.data[PERIOD_W-1:0] = cfg.period;
            default: rd.resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            r <= rd;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            r_valid  <= r_valid_n;
            ar_ready <= !r_valid_n;
        end
    end

endmodule

//--- rtl/adc_subsystem.sv
module adc_subsystem import adc_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  axil_aw_t aw,
    input  logic     aw_valid,
    output logic     aw_ready,
    input  axil_w_t  w,
    input  logic     w_valid,
    output logic     w_ready,
    output axil_b_t  b,
    output logic     b_valid,
    input  logic     b_ready,
    input  axil_ar_t ar,
    input  logic     ar_valid,
    output logic     ar_ready,
    output axil_r_t  r,
    output logic     r_valid,
    input  logic     r_ready,

    output logic     cs,
    output logic     sclk,
    input  logic     sdo
);

    adc_cfg_t           cfg;
    logic               recal_req;
    logic               calibrating;
    sample_t            smp;
    logic               smp_valid;
    logic               smp_ready;
    sample_t            fifo_data;
    logic               fifo_valid;
    logic [LEVEL_W-1:0] fifo_level;
    logic               pop;

    adc_spi_reader u_reader (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .recal_req   (recal_req),
        .sdo         (sdo),
        .in_ready    (smp_ready),
        .cs          (cs),
        .sclk        (sclk),
        .smp         (smp),
        .smp_valid   (smp_valid),
        .calibrating (calibrating)
    );

    sample_fifo #(.payload_t(sample_t)) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (smp),
        .in_valid  (smp_valid),
        .in_ready  (smp_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (pop),
        .level     (fifo_level)
    );

    adc_axil_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r           (r),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .fifo_data   (fifo_data),
        .fifo_valid  (fifo_valid),
        .fifo_level  (fifo_level),
        .calibrating (calibrating),
        .cfg         (cfg),
        .recal_req   (recal_req),
        .pop         (pop)
    );

endmodule

//--- bench/adc_model.sv
module adc_model (
    input  logic cs,
    input  logic sclk,
    output logic sdo
);
    timeunit 1ns;
    timeprecision 1ps;

    int          conv_count;                                // Conversion frames seen so far
    int          cal_count;
    time         start_t;
    time         prev_start;
    time         last_gap;                                  // Start to start, in ns
    int          edges;
    int          idx;
    logic [15:0] word;

    function automatic logic [11:0] frame_value(input int k);
        return 12'((k * 37 + 5) % 4096);
    endfunction

    initial begin
        conv_count = 0;
        cal_count  = 0;
        sdo        = 1'b0;
        edges      = 0;
        idx        = 0;
        prev_start = 0;
        last_gap   = 0;
    end

    // First bit must be ready before the first rising sclk
    always @(negedge cs) begin
        word    = {4'b0000, frame_value(conv_count)};
        idx     = 15;
        sdo     = word[15];
        edges   = 0;
        start_t = $time;
    end

    always @(posedge sclk) begin
        if (!cs)
            edges++;
    end

    always @(negedge sclk) begin
        if (!cs && idx > 0) begin
            idx--;
            sdo = word[idx];
        end
    end

    always @(posedge cs) begin
        if (edges == 16) begin
            last_gap   = start_t - prev_start;
            prev_start = start_t;
            conv_count++;
        end else if (edges == 32) begin
            cal_count++;
        end
    end

endmodule

//--- bench/tb_adc_subsystem.sv
module tb_adc_subsystem import adc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT    = 20000;                      // clk cycles per wait loop

    logic     clk;
    logic     reset;
    axil_aw_t aw;
    logic     aw_valid;
    logic     aw_ready;
    axil_w_t  w;
    logic     w_valid;
    logic     w_ready;
    axil_b_t  b;
    logic     b_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     ar_ready;
    axil_r_t  r;
    logic     r_valid;
    logic     r_ready;
    logic     cs;
    logic     sclk;
    logic     sdo;

    integer      seed;
    int          data_errors = 0;
    int          other_errors = 0;
    int          next_k;
    string       cur_test;
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;

    adc_subsystem DUT (.*);

    adc_model u_adc (.cs(cs), .sclk(sclk), .sdo(sdo));

    always #(CLK_PERIOD / 2) clk = !clk;

    // ****************************************
    // Reference model
    // ****************************************
    function automatic logic [31:0] expected_value(input int k);
        return 32'((k * 37 + 5) % 4096);
    endfunction

    function automatic logic [31:0] data_word(input int k, input logic ovr);
        return 32'h8000_0000 | (32'(ovr) << 16) | expected_value(k);
    endfunction

    // Every DATA read lands here in order
    always @(posedge clk) begin
        while (act_q.size() != 0) begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            assert (cmp_act == cmp_exp) else begin
                data_errors++;
                $display("Error %s data: expected 0x%08h, actual 0x%08h",
                         cmp_name, cmp_exp, cmp_act);
            end
        end
    end

    // ****************************************
    // Bus and wait tasks
    // ****************************************
    task automatic fail_run(input string what);
        $display("Timed out waiting for %s", what);
        $display("Something failed");
        $finish;
    endtask

    task automatic idle_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(posedge clk);
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int   t;
        logic aw_done;
        logic w_done;
        idle_cycles();
        @(posedge clk);
        aw.addr  <= addr;
        aw_valid <= 1'b1;
        w.data   <= data;
        w_valid  <= 1'b1;
        b_ready  <= 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        t = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (!aw_done && aw_ready) begin
                aw_done = 1'b1;
                aw_valid <= 1'b0;
            end
            if (!w_done && w_ready) begin
                w_done = 1'b1;
                w_valid <= 1'b0;
            end
            t++;
            if (t > 100)
                fail_run("AW or W ready");
        end
        t = 0;
        @(posedge clk);
        while (!b_valid) begin
            t++;
            if (t > 100)
                fail_run("write response");
            @(posedge clk);
        end
        resp = b.resp;
        b_ready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int t;
        idle_cycles();
        @(posedge clk);
        ar.addr  <= addr;
        ar_valid <= 1'b1;
        r_ready  <= 1'b1;
        t = 0;
        @(posedge clk);
        while (!ar_ready) begin
            t++;
            if (t > 100)
                fail_run("AR ready");
            @(posedge clk);
        end
        ar_valid <= 1'b0;
        t = 0;
        @(posedge clk);
        while (!r_valid) begin
            t++;
            if (t > 100)
                fail_run("read data");
            @(posedge clk);
        end
        data = r.data;
        resp = r.resp;
        r_ready <= 1'b0;
    endtask

    task automatic compare_field(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act == exp) else begin
            other_errors++;
            $display("Error %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
        end
    endtask

    task automatic read_data(input logic [31:0] exp);
        logic [31:0] d;
        logic [1:0]  rs;
        axil_read(32'(REG_DATA), d, rs);
        name_q.push_back(cur_test);
        exp_q.push_back(exp);
        act_q.push_back(d);
    endtask

    task automatic wait_conv(input int target);
        int t;
        t = 0;
        while (u_adc.conv_count < target) begin
            t++;
            if (t > TIMEOUT)
                fail_run("conversion frames at the ADC model");
            @(posedge clk);
        end
    endtask

    task automatic wait_cal(input int target);
        int t;
        t = 0;
        while (u_adc.cal_count < target) begin
            t++;
            if (t > TIMEOUT)
                fail_run("calibration frames at the ADC model");
            @(posedge clk);
        end
    endtask

    task automatic wait_cs_high();
        int t;
        t = 0;
        while (!cs) begin
            t++;
            if (t > TIMEOUT)
                fail_run("chip select to go high");
            @(posedge clk);
        end
    endtask

    // Disables conversions, lets the running frame finish and empties the FIFO
    task automatic stop_and_drain();
        logic [31:0] d;
        logic [1:0]  rs;
        axil_write(32'(REG_CTRL), 32'h0, rs);
        wait_cs_high();
        for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
            axil_read(32'(REG_DATA), d, rs);
            name_q.push_back(cur_test);
            act_q.push_back(d);
            if (!d[DATA_VALID_BIT]) begin
                exp_q.push_back(32'h0);
                break;
            end
            exp_q.push_back(data_word(next_k, 1'b0));
            next_k++;
        end
        compare_field("frames read", 32'(u_adc.conv_count), 32'(next_k));
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        logic [31:0] d;
        logic [1:0]  rs;
        int          first;
        int          total;
        int          k0;
        int          conv0;

        seed     = 8;
        clk      = 1'b0;
        reset    = 1'b1;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        next_k   = 0;
        cur_test = "calibration";
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        axil_read(32'(REG_STATUS), d, rs);
        compare_field("calibrating", 32'h1, 32'(d[STAT_CAL_BIT]));
        wait_cal(1);
        axil_read(32'(REG_STATUS), d, rs);
        compare_field("calibrating", 32'h0, 32'(d[STAT_CAL_BIT]));
        compare_field("conversions", 32'h0, 32'(u_adc.conv_count));
        read_data(32'h0);

        cur_test = "registers";
        axil_write(32'(REG_PERIOD), 32'd200, rs);
        compare_field("period resp", 32'(RESP_OKAY), 32'(rs));
        axil_write(32'(REG_CTRL), 32'h0, rs);
        compare_field("ctrl resp", 32'(RESP_OKAY), 32'(rs));
        axil_write(32'h10, 32'hFFFF_FFFF, rs);
        compare_field("unmapped write resp", 32'(RESP_SLVERR), 32'(rs));
        axil_write(32'(REG_STATUS), 32'h1, rs);
        compare_field("status write resp", 32'(RESP_SLVERR), 32'(rs));
        axil_read(32'h10, d, rs);
        compare_field("unmapped read resp", 32'(RESP_SLVERR), 32'(rs));
        compare_field("unmapped read data", 32'h0, d);
        axil_read(32'(REG_PERIOD), d, rs);
        compare_field("period", 32'd200, d);
        axil_read(32'(REG_CTRL), d, rs);
        compare_field("ctrl", 32'h0, d);

        cur_test = "ordered";
        axil_write(32'(REG_CTRL), 32'h1, rs);
        axil_read(32'(REG_CTRL), d, rs);
        compare_field("ctrl", 32'h1, d);
        for (int k = 0; k < 10; k++) begin
            wait_conv(k + 1);                               // Reads fit in the quiet gap
            axil_read(32'(REG_STATUS), d, rs);
            compare_field("available", 32'h1, 32'(d[STAT_AVAIL_BIT]));
            compare_field("level", 32'(u_adc.conv_count - k), 32'(d[8:4]));
            read_data(data_word(next_k, 1'b0));
            next_k++;
        end
        stop_and_drain();

        cur_test = "overrun";
        first = u_adc.conv_count;
        axil_write(32'(REG_CTRL), 32'h1, rs);
        wait_conv(first + FIFO_DEPTH + 3);
        axil_write(32'(REG_CTRL), 32'h0, rs);
        wait_cs_high();
        total = u_adc.conv_count - first;
        read_data(data_word(next_k, 1'b0));
        next_k++;
        // One more frame now that a slot is free
        axil_write(32'(REG_CTRL), 32'h1, rs);
        wait_conv(first + total + 1);
        axil_write(32'(REG_CTRL), 32'h0, rs);
        wait_cs_high();
        for (int i = 1; i < FIFO_DEPTH; i++) begin
            read_data(data_word(next_k, 1'b0));
            next_k++;
        end
        read_data(data_word(first + FIFO_DEPTH + (total - FIFO_DEPTH), 1'b1));
        read_data(32'h0);
        next_k = u_adc.conv_count;

        cur_test = "clamp";
        axil_write(32'(REG_PERIOD), 32'd10, rs);
        axil_write(32'(REG_CTRL), 32'h1, rs);
        k0 = u_adc.conv_count;
        wait_conv(k0 + 1);
        for (int i = 2; i <= 5; i++) begin
            wait_conv(k0 + i);
            assert (u_adc.last_gap >= MIN_PERIOD * CLK_PERIOD) else begin
                other_errors++;
                $display("Error %s gap: expected >= %0d ns, actual %0d ns",
                         cur_test, MIN_PERIOD * CLK_PERIOD, u_adc.last_gap);
            end
        end
        stop_and_drain();

        cur_test = "recalibration";
        k0    = u_adc.cal_count;
        conv0 = u_adc.conv_count;
        axil_write(32'(REG_CTRL), 32'h2, rs);
        wait_cal(k0 + 1);
        // Room for a second calibration frame to start and finish
        repeat (2 * (CAL_SCLKS + QUIET_SCLKS) * 2 * SCLK_DIV) @(posedge clk);
        axil_read(32'(REG_STATUS), d, rs);
        compare_field("calibrating", 32'h0, 32'(d[STAT_CAL_BIT]));
        compare_field("available", 32'h0, 32'(d[STAT_AVAIL_BIT]));
        compare_field("level", 32'h0, 32'(d[8:4]));
        compare_field("calibrations", 32'(k0 + 1), 32'(u_adc.cal_count));
        compare_field("conversions", 32'(conv0), 32'(u_adc.conv_count));
        read_data(32'h0);

        repeat (2) @(posedge clk);
        $display("Checks done with %0d data errors and %0d other errors",
                 data_errors, other_errors);
        if (data_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- adc_subsystem.f
rtl/adc_pkg.sv
rtl/adc_spi_reader.sv
rtl/sample_fifo.sv
rtl/adc_axil_regs.sv
rtl/adc_subsystem.sv
bench/adc_model.sv
bench/tb_adc_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_adc_subsystem \
    -f adc_subsystem.f --Mdir obj_dir -o sim_adc
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_adc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
